// File: Makefile
# Verilator flow for the vec_mem project
VERILATOR ?= verilator
TOP       ?= tb_vec_mem
RTL_TOP   ?= vec_mem_top
FILELIST  ?= vec_mem.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS     := $(filter-out +%,$(shell cat $(FILELIST)))
RTL_SRCS := $(filter-out verification/%,$(SRCS))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS) verification/tb_mem_model.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "Simulation ended without a pass line"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/vec_mem_pkg.sv
/*
 Shared constants and the CPU status word for the memory subsystem.
 Load offsets follow the file indices of the loader menu.
 Erase constants cover only the 64 KB main bank.
*/
package vec_mem_pkg;

	// ----------------------------------------
	// Bus widths
	// ----------------------------------------
	localparam int CPU_AW = 16;
	// Eight 64 KB banks: main, E-disk and loader areas
	localparam int RAM_AW = 19;
	localparam int DL_AW  = 25;

	// E-disk control register port
	localparam logic [7:0] EDSK_PORT = 8'h10;

	// ----------------------------------------
	// Loader file indices and offsets
	// ----------------------------------------
	localparam logic [7:0] DL_IDX_BOOT = 8'h00;
	localparam logic [7:0] DL_IDX_ROM  = 8'h01;
	localparam logic [7:0] DL_IDX_COM  = 8'h41;
	localparam logic [7:0] DL_IDX_C00  = 8'h81;
	localparam logic [7:0] DL_IDX_EDD  = 8'hC1;

	localparam logic [DL_AW-1:0] DL_OFS_BOOT = 25'h0050000;
	localparam logic [DL_AW-1:0] DL_OFS_PROG = 25'h0000100;
	localparam logic [DL_AW-1:0] DL_OFS_EDD  = 25'h0010000;

	// ----------------------------------------
	// Erase engine
	// ----------------------------------------
	// One write per divider wrap
	localparam int ERASE_PACE_W = 6;
	localparam logic [CPU_AW-1:0] ERASE_MASK = 16'hFFFF;
	localparam logic [CPU_AW-1:0] ERASE_END  = 16'h0100;

	// Erase FSM state codes
	localparam logic [1:0] ERS_IDLE    = 2'd0;
	localparam logic [1:0] ERS_ARMED   = 2'd1;
	localparam logic [1:0] ERS_ERASING = 2'd2;

	// ----------------------------------------
	// CPU status word
	// ----------------------------------------
	// Idle status after reset, only write_n set so nothing writes
	localparam logic [7:0] STATUS_IDLE = 8'h02;

	// Same byte seen raw or as the eight 8080 status flags
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic ram_read;
			logic io_read;
			logic m1;
			logic io_write;
			logic halt_ack;
			logic io_stack;
			logic write_n;
			logic int_ack;
		} flags;
	} cpu_status_u;

endpackage

// File: edisk/edisk_pager.sv
/*
 E-disk control register and page selection for the 256 KB RAM disk.
 Page 0 is the main bank, pages 1 to 4 are the E-disk banks.
 The register holds its value until the next cold reset.
*/
module edisk_pager (
	input  logic                     clk_sys,
	input  logic                     cold_reset,
	input  logic                     edsk_wr_i,
	input  logic [7:0]               cpu_dout_i,
	// Address bits 15:13
	input  logic [2:0]               cpu_addr_i,
	input  vec_mem_pkg::cpu_status_u status_i,
	input  logic                     mreq_i,
	output logic [2:0]               ed_page_o
);

	// Bits 3:2 stack bank, 1:0 window bank
	// Bit 4 stack enable, bit 5 window enable
	// Bit 6 adds 8000h quarter, bit 7 adds E000h quarter
	logic [7:0] ed_reg;
	logic       ed_win;
	logic       ed_stack;
	logic       ed_ram;

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			ed_reg <= 8'h00;
		end else if (edsk_wr_i) begin
			ed_reg <= cpu_dout_i;
		end
	end

	// ----------------------------------------
	// Window decode
	// ----------------------------------------
	// A000h-DFFFh always, 8000h and E000h quarters optional
	assign ed_win = cpu_addr_i[2] & (
		(cpu_addr_i[1] ^ cpu_addr_i[0]) |
		(ed_reg[7] & cpu_addr_i[1] & cpu_addr_i[0]) |
		(ed_reg[6] & ~cpu_addr_i[1] & ~cpu_addr_i[0]));

	assign ed_stack = ed_reg[4] & status_i.flags.io_stack & mreq_i;
	assign ed_ram   = ed_reg[5] & ed_win & mreq_i;

	// Stack access wins over the window
	always_comb begin
		if (ed_stack) begin
			ed_page_o = {1'b0, ed_reg[3:2]} + 3'd1;
		end else if (ed_ram) begin
			ed_page_o = {1'b0, ed_reg[1:0]} + 3'd1;
		end else begin
			ed_page_o = 3'd0;
		end
	end

endmodule

// File: erase/erase_counter.sv
/*
 Erase address generator, one zero write per divider wrap.
 The address wraps at 64 KB and stops before ERASE_END.
*/
module erase_counter (
	input  logic                           clk_sys,
	input  logic                           cold_reset,
	input  logic                           load_i,
	input  logic                           run_i,
	input  logic [vec_mem_pkg::CPU_AW-1:0] start_addr_i,
	output logic [vec_mem_pkg::CPU_AW-1:0] erase_addr_o,
	output logic                           erase_wr_o,
	output logic                           at_end_o
);
	import vec_mem_pkg::*;

	logic [ERASE_PACE_W-1:0] div_q;
	logic [CPU_AW-1:0]       addr_q;
	logic [CPU_AW-1:0]       next_addr;
	logic                    wrap;
	logic                    wr_q;

	assign next_addr = (addr_q + 1'b1) & ERASE_MASK;
	assign wrap      = run_i & (div_q == '0);
	assign at_end_o  = wrap & (next_addr == ERASE_END);

	// ----------------------------------------
	// Pace divider and write strobe
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			div_q <= '0;
			wr_q  <= 1'b0;
		end else begin
			wr_q <= wrap & ~at_end_o;
			if (load_i) begin
				div_q <= '0;
			end else if (run_i) begin
				div_q <= div_q + 1'b1;
			end
		end
	end

	// Address steps, then the write follows a clock later
	always_ff @(posedge clk_sys) begin
		if (load_i) begin
			addr_q <= start_addr_i;
		end else if (wrap && !at_end_o) begin
			addr_q <= next_addr;
		end
	end

	assign erase_addr_o = addr_q;
	assign erase_wr_o   = wr_q;

endmodule

// File: erase/erase_fsm.sv
/*
 Erase control after a ROM or COM download.
 A new download aborts a running erase.
*/
module erase_fsm (
	input  logic       clk_sys,
	input  logic       cold_reset,
	input  logic       dl_active_i,
	input  logic [7:0] dl_index_i,
	input  logic       at_end_i,
	output logic       load_o,
	output logic       run_o,
	output logic       erasing_o
);
	import vec_mem_pkg::*;

	logic [1:0] state_q;
	logic [1:0] state_d;
	logic       prog_load;

	assign prog_load = (dl_index_i == DL_IDX_ROM) || (dl_index_i == DL_IDX_COM);

	always_comb begin
		state_d = state_q;
		if (dl_active_i) begin
			// Last download index decides
			state_d = prog_load ? ERS_ARMED : ERS_IDLE;
		end else begin
			case (state_q)
				ERS_ARMED: begin
					state_d = ERS_ERASING;
				end
				ERS_ERASING: begin
					if (at_end_i) begin
						state_d = ERS_IDLE;
					end
				end
				default: begin
					state_d = ERS_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			state_q <= ERS_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Download just ended
	assign load_o    = (state_q == ERS_ARMED) & ~dl_active_i;
	assign run_o     = (state_q == ERS_ERASING) & ~dl_active_i;
	assign erasing_o = (state_q == ERS_ERASING);

	// End of erase only comes from a running counter
	a_end_while_running : assert property (@(posedge clk_sys) disable iff (cold_reset)
		at_end_i |-> run_o);

endmodule

// File: vec_mem.f
+incdir+verification
common/vec_mem_pkg.sv
verilog/bus_cycle_decoder.sv
edisk/edisk_pager.sv
verilog/mem_port_arbiter.sv
verilog/main_ram.sv
erase/erase_fsm.sv
erase/erase_counter.sv
verilog/vec_mem_top.sv
verification/tb_vec_mem.sv

// File: verification/tb_mem_model.svh
/*
 Flat reference memory for the testbench, 512 KB, no address scrambling.
 Holds the load offset rule, the E-disk page rule and the erase rule.
*/
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// Bank in bits 18:16, CPU address below
logic [7:0] ref_mem [0:(1 << 19) - 1];

// Offset added to a loader address for a given file index
function automatic logic [24:0] load_offset(input logic [7:0] index);
	case (index)
		8'h00: return 25'h0050000;
		8'h01, 8'h41: return 25'h0000100;
		8'hC1: return 25'h0010000;
		// C00 and unknown files
		default: return 25'h0000000;
	endcase
endfunction

// ----------------------------------------
// E-disk page rule
// ----------------------------------------
function automatic logic [2:0] page_select(input logic [7:0] ed_reg, input logic [15:0] addr,
	input logic stack);
	logic in_window;
	in_window = (addr >= 16'hA000 && addr <= 16'hDFFF) ||
		(ed_reg[6] && addr >= 16'h8000 && addr <= 16'h9FFF) ||
		(ed_reg[7] && addr >= 16'hE000);
	if (stack && ed_reg[4]) begin
		return {1'b0, ed_reg[3:2]} + 3'd1;
	end else if (in_window && ed_reg[5]) begin
		return {1'b0, ed_reg[1:0]} + 3'd1;
	end else begin
		return 3'd0;
	end
endfunction

// ----------------------------------------
// Erase rule
// ----------------------------------------
// Zero from one past the load end, wrapping at 64 KB, up to 00FFh
task automatic erase_range(input logic [15:0] load_end);
	logic [15:0] a;
	a = load_end + 16'd1;
	while (a != 16'h0100) begin
		ref_mem[{3'd0, a}] = 8'h00;
		a = a + 16'd1;
	end
endtask

`endif

// File: verification/tb_vec_mem.sv
/*
 Testbench for vec_mem_top against a flat reference memory.
 The erase check waits out a full 64 KB erase, several million clocks.
*/
module tb_vec_mem;

	localparam int DRIVE_DLY = 10;

	logic        clk_sys;
	logic        cold_reset;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dout;
	logic        cpu_sync;
	logic        cpu_wr_n;
	logic [7:0]  cpu_data;
	logic        dl_active;
	logic [7:0]  dl_index;
	logic [24:0] dl_addr;
	logic [7:0]  dl_data;
	logic        dl_wr;
	logic        erasing;

	logic [31:0] lcg_state;
	logic [15:0] probe [0:15];
	logic [15:0] last_end;

	`include "tb_mem_model.svh"

	vec_mem_top dut (
		.clk_sys     (clk_sys),
		.cold_reset  (cold_reset),
		.cpu_addr_i  (cpu_addr),
		.cpu_dout_i  (cpu_dout),
		.cpu_sync_i  (cpu_sync),
		.cpu_wr_n_i  (cpu_wr_n),
		.cpu_data_o  (cpu_data),
		.dl_active_i (dl_active),
		.dl_index_i  (dl_index),
		.dl_addr_i   (dl_addr),
		.dl_data_i   (dl_data),
		.dl_wr_i     (dl_wr),
		.erasing_o   (erasing)
	);

	always #50 clk_sys = ~clk_sys;

	function automatic logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	task automatic next_cycle();
		@(posedge clk_sys);
		#DRIVE_DLY;
	endtask

	task automatic apply_reset();
		cold_reset = 1'b1;
		repeat (10) next_cycle();
		cold_reset = 1'b0;
	endtask

	task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s, got %02h, expected %02h", $time, what, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t while waiting for %s", $time, what);
		$display("TEST FAIL");
		$fatal(1, "timeout");
	endtask

	// ----------------------------------------
	// CPU bus
	// ----------------------------------------
	// Status byte rides on the data bus while sync is high
	task automatic cpu_start(input logic [7:0] status, input logic [15:0] addr);
		cpu_sync = 1'b1;
		cpu_dout = status;
		cpu_addr = addr;
		next_cycle();
		cpu_sync = 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] addr, input logic stack, output logic [7:0] data);
		// ram_read and write_n, io_stack for a stack access
		cpu_start({5'b10000, stack, 2'b10}, addr);
		next_cycle();
		data = cpu_data;
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic stack, input logic [7:0] data);
		cpu_start({5'b00000, stack, 2'b00}, addr);
		cpu_dout = data;
		cpu_wr_n = 1'b0;
		next_cycle();
		cpu_wr_n = 1'b1;
	endtask

	// Port number appears on both address halves
	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		cpu_start(8'h10, {port, port});
		cpu_dout = data;
		cpu_wr_n = 1'b0;
		next_cycle();
		cpu_wr_n = 1'b1;
		next_cycle();
	endtask

	task automatic read_and_check(input logic [15:0] addr, input logic stack, input logic [2:0] page);
		logic [7:0] data;
		cpu_read(addr, stack, data);
		check_value(data, ref_mem[{page, addr}], $sformatf("read %04h page %0d", addr, page));
	endtask

	// ----------------------------------------
	// Loader
	// ----------------------------------------
	task automatic dl_begin(input logic [7:0] index);
		dl_index = index;
		dl_active = 1'b1;
		next_cycle();
	endtask

	task automatic dl_byte(input logic [24:0] addr, input logic [7:0] data);
		logic [24:0] flat;
		flat = addr + load_offset(dl_index);
		ref_mem[flat[18:0]] = data;
		last_end = flat[15:0];
		dl_addr = addr;
		dl_data = data;
		dl_wr = 1'b1;
		next_cycle();
		dl_wr = 1'b0;
		next_cycle();
	endtask

	task automatic dl_end();
		dl_active = 1'b0;
		next_cycle();
	endtask

	task automatic wait_erasing(input logic level, input int limit, input string what);
		int cnt;
		cnt = 0;
		while (erasing !== level) begin
			if (cnt >= limit) begin
				report_timeout(what);
			end
			next_cycle();
			cnt = cnt + 1;
		end
	endtask

	initial begin
		int n;
		logic [15:0] r;
		logic [15:0] addr;
		logic [7:0]  ed_reg;
		logic        stack;
		logic [15:0] addr_list [0:31];

		clk_sys = 1'b0;
		cold_reset = 1'b1;
		cpu_addr = '0;
		cpu_dout = '0;
		cpu_sync = 1'b0;
		cpu_wr_n = 1'b1;
		dl_active = 1'b0;
		dl_index = '0;
		dl_addr = '0;
		dl_data = '0;
		dl_wr = 1'b0;
		lcg_state = 32'd13;
		// One probe in each 4 KB block, 1010h is where a stray I/O write would land
		for (int i = 0; i < 16; i++) begin
			r = next_rand();
			probe[i] = {i[3:0], r[11:0]};
		end
		probe[1] = 16'h1010;
		apply_reset();

		// C00 load fills the probes in banks 0 to 4
		dl_begin(8'h81);
		for (int b = 0; b < 5; b++) begin
			for (int i = 0; i < 16; i++) begin
				r = next_rand();
				dl_byte({6'd0, b[2:0], probe[i]}, r[7:0]);
			end
		end
		dl_end();
		// EDD load into the first E-disk bank, window range only
		dl_begin(8'hC1);
		for (int i = 0; i < 16; i++) begin
			r = next_rand();
			addr_list[i] = 16'hA000 | {2'b00, i[3:0], 2'b00, r[7:0]};
			dl_byte({9'd0, addr_list[i]}, r[15:8]);
		end
		dl_end();
		for (int i = 0; i < 16; i++) begin
			read_and_check(probe[i], 1'b0, 3'd0);
		end
		io_write(8'h10, 8'h20);
		for (int i = 0; i < 16; i++) begin
			read_and_check(addr_list[i], 1'b0, page_select(8'h20, addr_list[i], 1'b0));
		end
		io_write(8'h10, 8'h00);

		// Plain writes and reads in the main bank
		for (int i = 0; i < 32; i++) begin
			addr_list[i] = next_rand();
			r = next_rand();
			cpu_write(addr_list[i], 1'b0, r[7:0]);
			ref_mem[{3'd0, addr_list[i]}] = r[7:0];
		end
		for (int i = 0; i < 32; i++) begin
			read_and_check(addr_list[i], 1'b0, 3'd0);
		end

		// Random page register with window and stack reads
		for (int k = 0; k < 48; k++) begin
			r = next_rand();
			ed_reg = r[7:0];
			stack = r[8];
			io_write(8'h10, ed_reg);
			addr = probe[r[15:12]];
			read_and_check(addr, stack, page_select(ed_reg, addr, stack));
		end
		io_write(8'h10, 8'h00);
		read_and_check(16'h1010, 1'b0, 3'd0);

		// ----------------------------------------
		// Short COM load, then the erase
		// ----------------------------------------
		dl_begin(8'h41);
		r = next_rand();
		n = 16 + int'(r[3:0]);
		for (int i = 0; i < n; i++) begin
			r = next_rand();
			dl_byte(25'(i), r[7:0]);
		end
		dl_end();
		wait_erasing(1'b1, 8, "erasing_o to rise");
		wait_erasing(1'b0, 70000 * 64, "erasing_o to fall");
		erase_range(last_end);
		for (int a = 0; a < 65536; a++) begin
			read_and_check(a[15:0], 1'b0, 3'd0);
		end

		// Reset must clear the page register
		io_write(8'h10, 8'h20);
		addr = probe[10];
		r = next_rand();
		cpu_write(addr, 1'b0, r[7:0] | 8'h01);
		ref_mem[{page_select(8'h20, addr, 1'b0), addr}] = r[7:0] | 8'h01;
		read_and_check(addr, 1'b0, page_select(8'h20, addr, 1'b0));
		apply_reset();
		read_and_check(addr, 1'b0, page_select(8'h00, addr, 1'b0));

		$display("TEST PASS");
		$finish;
	end

endmodule

// File: verilog/bus_cycle_decoder.sv
/*
 Captures the 8080 status byte at the rising edge of sync.
 edsk_wr_o is one clock wide, on the first low clock of the write strobe.
*/
module bus_cycle_decoder (
	input  logic                     clk_sys,
	input  logic                     cold_reset,
	input  logic                     cpu_sync_i,
	input  logic [7:0]               cpu_dout_i,
	input  logic                     cpu_wr_n_i,
	input  logic [7:0]               cpu_addr_i,
	output vec_mem_pkg::cpu_status_u status_o,
	output logic                     mreq_o,
	output logic                     edsk_wr_o
);
	import vec_mem_pkg::*;

	logic        sync_q;
	cpu_status_u status_q;
	logic        io_wr;
	logic        edsk_we;
	logic        edsk_we_q;

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			sync_q       <= 1'b0;
			status_q.raw <= STATUS_IDLE;
			edsk_we_q    <= 1'b0;
		end else begin
			sync_q    <= cpu_sync_i;
			edsk_we_q <= edsk_we;
			// New machine cycle
			if (cpu_sync_i && !sync_q) begin
				status_q.raw <= cpu_dout_i;
			end
		end
	end

	assign io_wr   = status_q.flags.io_write & ~cpu_wr_n_i;
	assign edsk_we = io_wr & (cpu_addr_i == EDSK_PORT);

	// Strobe only on the falling edge of the write
	assign edsk_wr_o = edsk_we & ~edsk_we_q;

	assign mreq_o = (status_q.flags.ram_read | ~status_q.flags.write_n) &
		~status_q.flags.io_write & ~status_q.flags.io_read;
	assign status_o = status_q;

	// Write strobe stays high while the status byte is on the bus
	a_sync_no_write : assert property (@(posedge clk_sys) disable iff (cold_reset)
		$rose(cpu_sync_i) |-> cpu_wr_n_i);

endmodule

// File: verilog/main_ram.sv
/*
 Single-port byte RAM, 512 KB, one clock read latency.
 A write returns the new byte on the same port.
*/
module main_ram (
	input  logic                           clk_sys,
	input  logic [vec_mem_pkg::RAM_AW-1:0] addr_i,
	input  logic [7:0]                     din_i,
	input  logic                           we_i,
	output logic [7:0]                     dout_o
);
	import vec_mem_pkg::*;

	logic [7:0] mem [0:(1 << RAM_AW)-1];

	// Write-first port
	always_ff @(posedge clk_sys) begin
		if (we_i) begin
			mem[addr_i] <= din_i;
			dout_o      <= din_i;
		end else begin
			dout_o <= mem[addr_i];
		end
	end

endmodule

// File: verilog/mem_port_arbiter.sv
/*
 RAM port mux with loader over eraser over CPU priority.
 Loader addresses get the offset picked by the file index.
 RAM address bits are reordered, so the RAM contents are not in linear order.
*/
module mem_port_arbiter (
	input  logic                           clk_sys,
	input  logic                           dl_active_i,
	input  logic [7:0]                     dl_index_i,
	input  logic [vec_mem_pkg::DL_AW-1:0]  dl_addr_i,
	input  logic [7:0]                     dl_data_i,
	input  logic                           dl_wr_i,
	input  logic                           erasing_i,
	input  logic [vec_mem_pkg::CPU_AW-1:0] erase_addr_i,
	input  logic                           erase_wr_i,
	input  logic [vec_mem_pkg::CPU_AW-1:0] cpu_addr_i,
	input  logic [7:0]                     cpu_dout_i,
	input  logic                           cpu_wr_n_i,
	input  vec_mem_pkg::cpu_status_u       status_i,
	input  logic [2:0]                     ed_page_i,
	input  logic                           erase_stall_i,
	output logic [vec_mem_pkg::CPU_AW-1:0] load_end_o,
	output logic [vec_mem_pkg::RAM_AW-1:0] ram_addr_o,
	output logic [7:0]                     ram_din_o,
	output logic                           ram_we_o
);
	import vec_mem_pkg::*;

	logic [DL_AW-1:0]  dl_ofs;
	logic [DL_AW-1:0]  dl_addr_ofs;
	logic [RAM_AW-1:0] flat_addr;
	logic              cpu_we;

	always_comb begin
		case (dl_index_i)
			DL_IDX_BOOT:            dl_ofs = DL_OFS_BOOT;
			DL_IDX_ROM, DL_IDX_COM: dl_ofs = DL_OFS_PROG;
			DL_IDX_EDD:             dl_ofs = DL_OFS_EDD;
			// C00 and unknown files load as is
			default:                dl_ofs = '0;
		endcase
	end

	assign dl_addr_ofs = dl_addr_i + dl_ofs;

	// Last loaded address, the eraser starts just past it
	always_ff @(posedge clk_sys) begin
		if (dl_wr_i) begin
			load_end_o <= dl_addr_ofs[CPU_AW-1:0];
		end
	end

	assign cpu_we = ~cpu_wr_n_i & ~status_i.flags.io_write & ~erase_stall_i;

	always_comb begin
		if (dl_active_i) begin
			flat_addr = dl_addr_ofs[RAM_AW-1:0];
			ram_din_o = dl_data_i;
			ram_we_o  = dl_wr_i;
		end else if (erasing_i) begin
			flat_addr = {{(RAM_AW-CPU_AW){1'b0}}, erase_addr_i};
			ram_din_o = 8'h00;
			ram_we_o  = erase_wr_i;
		end else begin
			flat_addr = {ed_page_i, cpu_addr_i};
			ram_din_o = cpu_dout_i;
			ram_we_o  = cpu_we;
		end
	end

	// Bank, low 13 bits, then bits 14:13
	assign ram_addr_o = {flat_addr[RAM_AW-1:15], flat_addr[12:0], flat_addr[14:13]};

endmodule

// File: verilog/vec_mem_top.sv
/*
 Memory side of the Vector 06C: status capture, E-disk paging, loader and erase.
 Read data follows the address by one clock, with no wait states.
 CPU accesses are ignored while erasing_o is high.
*/
module vec_mem_top (
	input  logic                           clk_sys,
	input  logic                           cold_reset,
	input  logic [vec_mem_pkg::CPU_AW-1:0] cpu_addr_i,
	input  logic [7:0]                     cpu_dout_i,
	input  logic                           cpu_sync_i,
	input  logic                           cpu_wr_n_i,
	output logic [7:0]                     cpu_data_o,
	input  logic                           dl_active_i,
	input  logic [7:0]                     dl_index_i,
	input  logic [vec_mem_pkg::DL_AW-1:0]  dl_addr_i,
	input  logic [7:0]                     dl_data_i,
	input  logic                           dl_wr_i,
	output logic                           erasing_o
);
	import vec_mem_pkg::*;

	cpu_status_u       status;
	logic              mreq;
	logic              edsk_wr;
	logic [2:0]        ed_page;
	logic              erase_load;
	logic              erase_run;
	logic              erase_wr;
	logic              erase_at_end;
	logic [CPU_AW-1:0] erase_addr;
	logic [CPU_AW-1:0] load_end;
	logic [RAM_AW-1:0] ram_addr;
	logic [7:0]        ram_din;
	logic              ram_we;

	// ----------------------------------------
	// CPU side
	// ----------------------------------------
	bus_cycle_decoder u_decoder (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.cpu_sync_i (cpu_sync_i),
		.cpu_dout_i (cpu_dout_i),
		.cpu_wr_n_i (cpu_wr_n_i),
		.cpu_addr_i (cpu_addr_i[7:0]),
		.status_o   (status),
		.mreq_o     (mreq),
		.edsk_wr_o  (edsk_wr)
	);

	edisk_pager u_pager (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.edsk_wr_i  (edsk_wr),
		.cpu_dout_i (cpu_dout_i),
		.cpu_addr_i (cpu_addr_i[CPU_AW-1:CPU_AW-3]),
		.status_i   (status),
		.mreq_i     (mreq),
		.ed_page_o  (ed_page)
	);

	// ----------------------------------------
	// RAM and its masters
	// ----------------------------------------
	mem_port_arbiter u_arbiter (
		.clk_sys       (clk_sys),
		.dl_active_i   (dl_active_i),
		.dl_index_i    (dl_index_i),
		.dl_addr_i     (dl_addr_i),
		.dl_data_i     (dl_data_i),
		.dl_wr_i       (dl_wr_i),
		.erasing_i     (erasing_o),
		.erase_addr_i  (erase_addr),
		.erase_wr_i    (erase_wr),
		.cpu_addr_i    (cpu_addr_i),
		.cpu_dout_i    (cpu_dout_i),
		.cpu_wr_n_i    (cpu_wr_n_i),
		.status_i      (status),
		.ed_page_i     (ed_page),
		.erase_stall_i (erasing_o),
		.load_end_o    (load_end),
		.ram_addr_o    (ram_addr),
		.ram_din_o     (ram_din),
		.ram_we_o      (ram_we)
	);

	main_ram u_ram (
		.clk_sys (clk_sys),
		.addr_i  (ram_addr),
		.din_i   (ram_din),
		.we_i    (ram_we),
		.dout_o  (cpu_data_o)
	);

	erase_fsm u_erase_fsm (
		.clk_sys     (clk_sys),
		.cold_reset  (cold_reset),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.at_end_i    (erase_at_end),
		.load_o      (erase_load),
		.run_o       (erase_run),
		.erasing_o   (erasing_o)
	);

	erase_counter u_erase_cnt (
		.clk_sys      (clk_sys),
		.cold_reset   (cold_reset),
		.load_i       (erase_load),
		.run_i        (erase_run),
		.start_addr_i (load_end),
		.erase_addr_o (erase_addr),
		.erase_wr_o   (erase_wr),
		.at_end_o     (erase_at_end)
	);

endmodule
